//--- tiny_cpu.f
cpu_pkg.sv
prog_mem.sv
fetch_decode.sv
alu.sv
cpu_regs.sv
tiny_cpu.sv
tb_tiny_cpu.sv

//--- Bender.yml
package:
  name: tiny_cpu

sources:
  - cpu_pkg.sv
  - prog_mem.sv
  - fetch_decode.sv
  - alu.sv
  - cpu_regs.sv
  - tiny_cpu.sv
  - target: simulation
    files:
      - tb_tiny_cpu.sv

//--- tb_tiny_cpu.sv
// directed testbench for the tiny cpu with program builder, lcg and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_tiny_cpu;

  logic           clk;
  logic           arst_n;
  logic           run;
  logic           prog_we;
  cpu_pkg::addr_t prog_addr;
  cpu_pkg::byte_t prog_data;
  cpu_pkg::byte_t in_data;
  cpu_pkg::byte_t out_data;
  logic           out_valid;

  cpu_pkg::byte_t prog_img [cpu_pkg::PROG_DEPTH];
  logic [31:0]    lcg_state;
  int             pulse_cnt;

  tiny_cpu u_tiny_cpu (
    .clk       (clk),
    .arst_n    (arst_n),
    .run       (run),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .in_data   (in_data),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // counts every output pulse, sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      pulse_cnt = pulse_cnt + 1;
    end
  end

  initial begin
    #100000;
    $display("watchdog expired, the simulation ran too long");
    abort_run();
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic cpu_pkg::byte_t next_rand_byte();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[23:16];
  endfunction

  function automatic cpu_pkg::byte_t instr_byte(input cpu_pkg::opcode_e op,
                                                input cpu_pkg::nibble_t opnd);
    return {op, opnd};
  endfunction

  task automatic check_byte(input string test_name, input cpu_pkg::byte_t expected,
                            input cpu_pkg::byte_t actual);
    if (actual !== expected) begin
      $display("error %s expected %02h actual %02h", test_name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_bit(input string test_name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s expected %b actual %b", test_name, expected, actual);
      abort_run();
    end
  endtask

  task automatic reset_dut();
    @(negedge clk);
    arst_n  = 1'b0;
    run     = 1'b0;
    prog_we = 1'b0;
    repeat (2) @(negedge clk);
    arst_n    = 1'b1;
    pulse_cnt = 0;
  endtask

  task automatic clear_image();
    for (int i = 0; i < cpu_pkg::PROG_DEPTH; i++) begin
      prog_img[i] = instr_byte(cpu_pkg::NOP, 4'd0);
    end
  endtask

  // writes the whole image with the core stopped
  task automatic load_program();
    run = 1'b0;
    for (int i = 0; i < cpu_pkg::PROG_DEPTH; i++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = cpu_pkg::addr_t'(i);
      prog_data = prog_img[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
  endtask

  task automatic wait_out(input string test_name, output cpu_pkg::byte_t data);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!out_valid) begin
      cycles++;
      if (cycles >= 100) begin
        $display("no output pulse within 100 cycles in %s", test_name);
        abort_run();
      end
      @(negedge clk);
    end
    data = out_data;
  endtask

  // stop before the program wraps around
  task automatic stop_and_settle();
    run = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_reset();
    reset_dut();
    check_bit("reset valid", 1'b0, out_valid);
    check_byte("reset data", 8'h00, out_data);
    clear_image();
    load_program();
    run = 1'b1;
    repeat (20) begin
      @(negedge clk);
      check_bit("nop program", 1'b0, out_valid);
    end
    run = 1'b0;
    check_byte("nop program pulses", 8'd0, cpu_pkg::byte_t'(pulse_cnt));
  endtask

  task automatic test_nibble_loads();
    cpu_pkg::byte_t got;
    reset_dut();
    clear_image();
    prog_img[0]  = instr_byte(cpu_pkg::LDA_LO, 4'ha);
    prog_img[1]  = instr_byte(cpu_pkg::LDA_HI, 4'h5);
    prog_img[2]  = instr_byte(cpu_pkg::OUT, 4'd0);
    prog_img[3]  = instr_byte(cpu_pkg::LDB_LO, 4'h3);
    prog_img[4]  = instr_byte(cpu_pkg::LDB_HI, 4'hc);
    prog_img[5]  = instr_byte(cpu_pkg::OUT, 4'd1);
    prog_img[6]  = instr_byte(cpu_pkg::LDC_LO, 4'he);
    prog_img[7]  = instr_byte(cpu_pkg::LDC_HI, 4'h7);
    prog_img[8]  = instr_byte(cpu_pkg::OUT, 4'd2);
    // high half only, low half of a stays
    prog_img[9]  = instr_byte(cpu_pkg::LDA_HI, 4'h9);
    prog_img[10] = instr_byte(cpu_pkg::OUT, 4'd0);
    load_program();
    run = 1'b1;
    wait_out("load a", got);
    check_byte("load a", cpu_pkg::byte_t'(5 * 16 + 10), got);
    wait_out("load b", got);
    check_byte("load b", cpu_pkg::byte_t'(12 * 16 + 3), got);
    wait_out("load c", got);
    check_byte("load c", cpu_pkg::byte_t'(7 * 16 + 14), got);
    wait_out("load a high only", got);
    check_byte("load a high only", cpu_pkg::byte_t'(9 * 16 + 10), got);
    stop_and_settle();
    check_byte("load pulses", 8'd4, cpu_pkg::byte_t'(pulse_cnt));
  endtask

  task automatic test_arith();
    cpu_pkg::byte_t   a;
    cpu_pkg::byte_t   b;
    cpu_pkg::byte_t   got;
    cpu_pkg::byte_t   expected;
    cpu_pkg::opcode_e op;
    string            name;
    for (int k = 0; k < 8; k++) begin
      a = next_rand_byte();
      b = next_rand_byte();
      case (k % 3)
        0: begin
          op       = cpu_pkg::ADD;
          name     = "arith add";
          expected = cpu_pkg::byte_t'((int'(a) + int'(b)) % 256);
        end
        1: begin
          op       = cpu_pkg::SUB;
          name     = "arith sub";
          expected = cpu_pkg::byte_t'((int'(a) - int'(b) + 256) % 256);
        end
        default: begin
          op       = cpu_pkg::MUL;
          name     = "arith mul";
          expected = cpu_pkg::byte_t'((int'(a) * int'(b)) % 256);
        end
      endcase
      reset_dut();
      clear_image();
      prog_img[0] = instr_byte(cpu_pkg::LDA_LO, a[3:0]);
      prog_img[1] = instr_byte(cpu_pkg::LDA_HI, a[7:4]);
      prog_img[2] = instr_byte(cpu_pkg::LDB_LO, b[3:0]);
      prog_img[3] = instr_byte(cpu_pkg::LDB_HI, b[7:4]);
      prog_img[4] = instr_byte(op, 4'd0);
      prog_img[5] = instr_byte(cpu_pkg::OUT, 4'd2);
      load_program();
      run = 1'b1;
      wait_out(name, got);
      check_byte(name, expected, got);
      stop_and_settle();
    end
  endtask

  task automatic test_input();
    cpu_pkg::byte_t v;
    cpu_pkg::byte_t got;
    v = next_rand_byte();
    reset_dut();
    clear_image();
    prog_img[0] = instr_byte(cpu_pkg::IN, 4'd1);
    prog_img[1] = instr_byte(cpu_pkg::OUT, 4'd1);
    prog_img[2] = instr_byte(cpu_pkg::IN, 4'd3);
    prog_img[3] = instr_byte(cpu_pkg::OUT, 4'd3);
    prog_img[4] = instr_byte(cpu_pkg::OUT, 4'd1);
    prog_img[5] = instr_byte(cpu_pkg::OUT, 4'd0);
    prog_img[6] = instr_byte(cpu_pkg::OUT, 4'd2);
    in_data = v;
    load_program();
    run = 1'b1;
    wait_out("in to b", got);
    check_byte("in to b", v, got);
    // a different byte that in 3 must not store anywhere
    in_data = ~v;
    wait_out("in operand 3", got);
    check_byte("in operand 3 keeps b", v, got);
    wait_out("in operand 3", got);
    check_byte("in operand 3 keeps a", 8'h00, got);
    wait_out("in operand 3", got);
    check_byte("in operand 3 keeps c", 8'h00, got);
    stop_and_settle();
    check_byte("input pulses", 8'd4, cpu_pkg::byte_t'(pulse_cnt));
  endtask

  task automatic test_pause();
    cpu_pkg::byte_t got;
    reset_dut();
    clear_image();
    prog_img[0] = instr_byte(cpu_pkg::LDA_LO, 4'h1);
    prog_img[1] = instr_byte(cpu_pkg::OUT, 4'd0);
    prog_img[2] = instr_byte(cpu_pkg::LDA_LO, 4'h2);
    prog_img[3] = instr_byte(cpu_pkg::OUT, 4'd0);
    prog_img[4] = instr_byte(cpu_pkg::LDA_LO, 4'h3);
    prog_img[5] = instr_byte(cpu_pkg::OUT, 4'd0);
    load_program();
    run = 1'b1;
    wait_out("pause first", got);
    check_byte("pause first", 8'h01, got);
    run = 1'b0;
    repeat (10) begin
      @(negedge clk);
      check_bit("paused", 1'b0, out_valid);
    end
    run = 1'b1;
    wait_out("pause second", got);
    check_byte("pause second", 8'h02, got);
    wait_out("pause third", got);
    check_byte("pause third", 8'h03, got);
    stop_and_settle();
    check_byte("pause pulses", 8'd3, cpu_pkg::byte_t'(pulse_cnt));
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    arst_n    = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    in_data   = '0;
    pulse_cnt = 0;
    lcg_state = 32'd38627;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    test_reset();
    test_nibble_loads();
    test_arith();
    test_input();
    test_pause();

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tiny_cpu.sv
// top level wiring program memory, decoder, alu and registers
`timescale 1ns/1ps
`default_nettype none

module tiny_cpu (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           run,
  input  logic           prog_we,
  input  cpu_pkg::addr_t prog_addr,
  input  cpu_pkg::byte_t prog_data,
  input  cpu_pkg::byte_t in_data,
  output cpu_pkg::byte_t out_data,
  output logic           out_valid
);

  //////////////////////////////
  // internal nets
  //////////////////////////////

  cpu_pkg::addr_t    pc;
  cpu_pkg::byte_t    instr;
  logic              wr_a;
  logic              wr_b;
  logic              wr_c;
  cpu_pkg::wr_src_e  wr_src;
  cpu_pkg::nibble_t  imm;
  cpu_pkg::alu_op_e  alu_op;
  logic              out_en;
  cpu_pkg::reg_sel_e out_sel;
  cpu_pkg::byte_t    reg_a;
  cpu_pkg::byte_t    reg_b;
  cpu_pkg::byte_t    alu_result;

  prog_mem u_prog_mem (
    .clk       (clk),
    .arst_n    (arst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .instr     (instr),
    .run       (run)
  );

  fetch_decode u_fetch_decode (
    .clk     (clk),
    .arst_n  (arst_n),
    .run     (run),
    .instr   (instr),
    .pc      (pc),
    .wr_a    (wr_a),
    .wr_b    (wr_b),
    .wr_c    (wr_c),
    .wr_src  (wr_src),
    .imm     (imm),
    .alu_op  (alu_op),
    .out_en  (out_en),
    .out_sel (out_sel)
  );

  alu u_alu (
    .a      (reg_a),
    .b      (reg_b),
    .alu_op (alu_op),
    .result (alu_result)
  );

  cpu_regs u_cpu_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_a       (wr_a),
    .wr_b       (wr_b),
    .wr_c       (wr_c),
    .wr_src     (wr_src),
    .imm        (imm),
    .alu_result (alu_result),
    .in_data    (in_data),
    .out_en     (out_en),
    .out_sel    (out_sel),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .out_data   (out_data),
    .out_valid  (out_valid)
  );

endmodule

`default_nettype wire

//--- cpu_regs.sv
// registers a, b and c with write-source select and the registered output port
`timescale 1ns/1ps
`default_nettype none

module cpu_regs (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              wr_a,
  input  logic              wr_b,
  input  logic              wr_c,
  input  cpu_pkg::wr_src_e  wr_src,
  input  cpu_pkg::nibble_t  imm,
  input  cpu_pkg::byte_t    alu_result,
  input  cpu_pkg::byte_t    in_data,
  input  logic              out_en,
  input  cpu_pkg::reg_sel_e out_sel,
  output cpu_pkg::byte_t    reg_a,
  output cpu_pkg::byte_t    reg_b,
  output cpu_pkg::byte_t    out_data,
  output logic              out_valid
);

  localparam int HI = cpu_pkg::DATA_W - 1;
  localparam int LO = cpu_pkg::OPND_W;

  cpu_pkg::byte_t reg_c;
  cpu_pkg::byte_t wr_old;
  cpu_pkg::byte_t wr_data;

  // current value of the target for the half loads
  always_comb begin
    wr_old = reg_c;
    if (wr_a) begin
      wr_old = reg_a;
    end else if (wr_b) begin
      wr_old = reg_b;
    end
  end

  always_comb begin
    case (wr_src)
      cpu_pkg::SRC_IMM_LO: wr_data = {wr_old[HI:LO], imm};
      cpu_pkg::SRC_IMM_HI: wr_data = {imm, wr_old[LO-1:0]};
      cpu_pkg::SRC_ALU:    wr_data = alu_result;
      default:             wr_data = in_data;
    endcase
  end

  //////////////////////////////
  // register file
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
    end else begin
      if (wr_a) reg_a <= wr_data;
      if (wr_b) reg_b <= wr_data;
      if (wr_c) reg_c <= wr_data;
    end
  end

  // output byte takes the value from before the edge and valid lasts one cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_data  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= out_en;
      if (out_en) begin
        case (out_sel)
          cpu_pkg::REG_A: out_data <= reg_a;
          cpu_pkg::REG_B: out_data <= reg_b;
          cpu_pkg::REG_C: out_data <= reg_c;
          default:        out_data <= out_data;
        endcase
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // wr_old serves a single target only
  a_wr_onehot0 : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0({wr_a, wr_b, wr_c})
  ) else $error("more than one register write enable");

  // an output request always names a register
  a_out_sel_named : assert property (
    @(posedge clk) disable iff (!arst_n)
    out_en |-> (out_sel != cpu_pkg::REG_NONE)
  ) else $error("out_en raised without a register to output");

endmodule

`default_nettype wire

//--- alu.sv
// combinational add, subtract and multiply of a and b, modulo 256
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_pkg::byte_t   a,
  input  cpu_pkg::byte_t   b,
  input  cpu_pkg::alu_op_e alu_op,
  output cpu_pkg::byte_t   result
);

  cpu_pkg::byte_t sum;
  cpu_pkg::byte_t diff;
  cpu_pkg::byte_t prod;

  assign sum  = a + b;
  // two's complement, invert b and add one
  assign diff = a + ~b + 1'b1;

  // shift-add rows, upper bits fall off
  always_comb begin
    prod = '0;
    for (int i = 0; i < cpu_pkg::DATA_W; i++) begin
      if (b[i]) begin
        prod = prod + cpu_pkg::byte_t'(a << i);
      end
    end
  end

  always_comb begin
    case (alu_op)
      cpu_pkg::ALU_SUB: result = diff;
      cpu_pkg::ALU_MUL: result = prod;
      default:          result = sum;
    endcase
  end

endmodule

`default_nettype wire

//--- fetch_decode.sv
// program counter and instruction decoder producing register-write controls
`timescale 1ns/1ps
`default_nettype none

module fetch_decode (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              run,
  input  cpu_pkg::byte_t    instr,
  output cpu_pkg::addr_t    pc,
  output logic              wr_a,
  output logic              wr_b,
  output logic              wr_c,
  output cpu_pkg::wr_src_e  wr_src,
  output cpu_pkg::nibble_t  imm,
  output cpu_pkg::alu_op_e  alu_op,
  output logic              out_en,
  output cpu_pkg::reg_sel_e out_sel
);

  cpu_pkg::opcode_e  opcode;
  cpu_pkg::nibble_t  operand;
  cpu_pkg::reg_sel_e opnd_sel;
  cpu_pkg::reg_sel_e dest;

  // one step per run edge and wraps from 15 back to 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (run) begin
      pc <= cpu_pkg::addr_t'(pc + 1'b1);
    end
  end

  assign opcode  = cpu_pkg::opcode_e'(instr[cpu_pkg::DATA_W-1:cpu_pkg::OPND_W]);
  assign operand = instr[cpu_pkg::OPND_W-1:0];

  // operands above 2 name no register
  always_comb begin
    case (operand)
      4'd0:    opnd_sel = cpu_pkg::REG_A;
      4'd1:    opnd_sel = cpu_pkg::REG_B;
      4'd2:    opnd_sel = cpu_pkg::REG_C;
      default: opnd_sel = cpu_pkg::REG_NONE;
    endcase
  end

  //////////////////////////////
  // decode
  //////////////////////////////

  always_comb begin
    dest   = cpu_pkg::REG_NONE;
    wr_src = cpu_pkg::SRC_IMM_LO;
    alu_op = cpu_pkg::ALU_ADD;
    out_en = 1'b0;
    if (run) begin
      case (opcode)
        cpu_pkg::LDA_LO, cpu_pkg::LDB_LO, cpu_pkg::LDC_LO: begin
          wr_src = cpu_pkg::SRC_IMM_LO;
          dest   = (opcode == cpu_pkg::LDA_LO) ? cpu_pkg::REG_A :
                   (opcode == cpu_pkg::LDB_LO) ? cpu_pkg::REG_B : cpu_pkg::REG_C;
        end
        cpu_pkg::LDA_HI, cpu_pkg::LDB_HI, cpu_pkg::LDC_HI: begin
          wr_src = cpu_pkg::SRC_IMM_HI;
          dest   = (opcode == cpu_pkg::LDA_HI) ? cpu_pkg::REG_A :
                   (opcode == cpu_pkg::LDB_HI) ? cpu_pkg::REG_B : cpu_pkg::REG_C;
        end
        cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::MUL: begin
          wr_src = cpu_pkg::SRC_ALU;
          dest   = cpu_pkg::REG_C;
          alu_op = (opcode == cpu_pkg::ADD) ? cpu_pkg::ALU_ADD :
                   (opcode == cpu_pkg::SUB) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_MUL;
        end
        cpu_pkg::IN: begin
          wr_src = cpu_pkg::SRC_IN;
          dest   = opnd_sel;
        end
        cpu_pkg::OUT: out_en = (opnd_sel != cpu_pkg::REG_NONE);
        default: dest = cpu_pkg::REG_NONE;
      endcase
    end
  end

  assign wr_a    = (dest == cpu_pkg::REG_A);
  assign wr_b    = (dest == cpu_pkg::REG_B);
  assign wr_c    = (dest == cpu_pkg::REG_C);
  assign imm     = operand;
  assign out_sel = opnd_sel;

endmodule

`default_nettype wire

//--- prog_mem.sv
// program store with external write port and combinational fetch at pc
`timescale 1ns/1ps
`default_nettype none

module prog_mem (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          prog_we,
  input  cpu_pkg::addr_t prog_addr,
  input  cpu_pkg::byte_t prog_data,
  input  cpu_pkg::addr_t pc,
  output cpu_pkg::byte_t instr,
  input  logic          run
);

  cpu_pkg::byte_t mem [cpu_pkg::PROG_DEPTH];

  // every byte clears to zero, which decodes as nop
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < cpu_pkg::PROG_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // fetch is zero-cycle, a byte written at an edge is visible right after it
  assign instr = mem[pc];

  //////////////////////////////
  // checks
  //////////////////////////////

  // the program may only change while the core is stopped
  a_no_write_while_run : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(prog_we && run)
  ) else $error("program write while run is high");

endmodule

`default_nettype wire

//--- cpu_pkg.sv
// widths, data types, opcode and control encodings shared by the tiny cpu
`default_nettype none

package cpu_pkg;

  //////////////////////////////
  // widths and sizes
  //////////////////////////////

  localparam int DATA_W     = 8;
  localparam int ADDR_W     = 4;
  localparam int PROG_DEPTH = 16;
  localparam int OPND_W     = 4;

  typedef logic [DATA_W-1:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [OPND_W-1:0] nibble_t;

  //////////////////////////////
  // instruction encodings
  //////////////////////////////

  // upper nibble of the instruction byte, codes 12 to 15 act as nop
  typedef enum logic [3:0] {
    NOP    = 4'd0,
    LDA_LO = 4'd1,
    LDA_HI = 4'd2,
    LDB_LO = 4'd3,
    LDB_HI = 4'd4,
    LDC_LO = 4'd5,
    LDC_HI = 4'd6,
    ADD    = 4'd7,
    SUB    = 4'd8,
    MUL    = 4'd9,
    OUT    = 4'd10,
    IN     = 4'd11
  } opcode_e;

  // register named by the operand of in and out
  typedef enum logic [1:0] {
    REG_A    = 2'd0,
    REG_B    = 2'd1,
    REG_C    = 2'd2,
    REG_NONE = 2'd3
  } reg_sel_e;

  // where a register write takes its data from
  typedef enum logic [1:0] {
    SRC_IMM_LO = 2'd0,
    SRC_IMM_HI = 2'd1,
    SRC_ALU    = 2'd2,
    SRC_IN     = 2'd3
  } wr_src_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_MUL = 2'd2
  } alu_op_e;

endpackage

`default_nettype wire
